/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_xsecure_dummy
FILELIST  ?= xsecure_dummy.f
SIM       ?= sim_$(TOP)
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(SIM)
	-./obj_dir/$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* source/dummy_instr_sched.sv */
`include "xsecure_defines.svh"

module dummy_instr_sched (
  input  logic                     xsecure_if,
  input  logic                     arst_n_i,
  input  logic                     rnddummy_i,
  input  logic [`XSEC_FREQ_W-1:0]  rnddummyfreq_i,
  input  xsecure_pkg::lfsr_taps_t  taps_i,
  input  logic                     real_issued_i,
  input  logic                     dummy_taken_i,
  output xsecure_pkg::dummy_req_t  dummy_req_o
);
  import xsecure_pkg::*;

  // Minor encodings of the four dummy kinds
  localparam logic [2:0] F3_ADD    = 3'b000;
  localparam logic [2:0] F3_AND    = 3'b111;
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_BLTU   = 3'b110;
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  logic [5:0]  freq_mask;
  logic [6:0]  threshold;
  logic [6:0]  cnt_q;
  logic [6:0]  cnt_next;
  logic        req_valid_q;
  logic        fire;
  instr_word_u word_d;
  instr_word_u req_word_q;

  // Frequency code to limit N, kept as N-1 since every limit is a power of two
  always_comb begin
    casez (rnddummyfreq_i)
      `XSEC_FREQ_4:  freq_mask = 6'd3;
      `XSEC_FREQ_8:  freq_mask = 6'd7;
      `XSEC_FREQ_16: freq_mask = 6'd15;
      `XSEC_FREQ_32: freq_mask = 6'd31;
      `XSEC_FREQ_64: freq_mask = 6'd63;
      default:       freq_mask = 6'd63;
    endcase
  end

  // Threshold lies in 1..N and changes when LFSR0 steps on a taken dummy
  assign threshold = 7'd1 + {1'b0, taps_i.lfsr0[5:0] & freq_mask};
  assign cnt_next  = cnt_q + {6'd0, real_issued_i};

  // Raise the request on the same edge that counts the last real item,
  // so no further real item can slip in ahead of the dummy
  assign fire = rnddummy_i && !req_valid_q && (cnt_next >= threshold);

  //////////////////////////////////////////////////
  // Dummy word
  //////////////////////////////////////////////////

  // Operands come from LFSR1 and LFSR2, the kind from LFSR0 bits 7:6
  always_comb begin
    word_d          = '0;
    word_d.r.rs1    = taps_i.lfsr1;
    word_d.r.rs2    = taps_i.lfsr2;
    word_d.r.rd     = 5'd0;
    word_d.r.opcode = `XSEC_OPC_OP;
    case (taps_i.lfsr0[7:6])
      2'b00: begin
        word_d.r.funct7 = F7_BASE;
        word_d.r.funct3 = F3_ADD;
      end
      2'b01: begin
        word_d.r.funct7 = F7_BASE;
        word_d.r.funct3 = F3_AND;
      end
      2'b10: begin
        word_d.r.funct7 = F7_MULDIV;
        word_d.r.funct3 = F3_MUL;
      end
      default: begin
        // Zero offset, so the branch lands on the next real instruction
        word_d.b.offset_hi = 7'd0;
        word_d.b.offset_lo = 5'd0;
        word_d.b.funct3    = F3_BLTU;
        word_d.b.opcode    = `XSEC_OPC_BRANCH;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Counter and request
  //////////////////////////////////////////////////

  always_ff @(posedge xsecure_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q       <= '0;
      req_valid_q <= 1'b0;
    end else begin
      // Count restarts after each dummy and stays idle while dummies are off
      if (dummy_taken_i || !rnddummy_i) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_next;
      end
      if (dummy_taken_i) begin
        req_valid_q <= 1'b0;
      end else if (fire) begin
        req_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge xsecure_if) begin
    if (fire) begin
      req_word_q <= word_d;
    end
  end

  assign dummy_req_o.valid = req_valid_q;
  assign dummy_req_o.instr = req_word_q;

  // Both views of the captured word are checked once the request is visible
  a_dummy_rd_x0: assert property (@(posedge xsecure_if) disable iff (!arst_n_i)
    fire |=> dummy_req_o.valid && dummy_req_o.instr.r.rd == 5'd0);

  a_bltu_zero_offset: assert property (@(posedge xsecure_if) disable iff (!arst_n_i)
    dummy_req_o.valid && dummy_req_o.instr.b.opcode == `XSEC_OPC_BRANCH
    |-> dummy_req_o.instr.b.funct3 == F3_BLTU
        && dummy_req_o.instr.b.offset_hi == 7'd0 && dummy_req_o.instr.b.offset_lo == 5'd0);

  // The issue stage takes a pending dummy at once
  a_req_one_cycle: assert property (@(posedge xsecure_if) disable iff (!arst_n_i)
    dummy_req_o.valid |=> !dummy_req_o.valid);

endmodule

/* source/fetch_fifo.sv */
`include "xsecure_defines.svh"

module fetch_fifo #(
  parameter int DEPTH = `XSEC_FIFO_DEPTH
) (
  input  logic                     xsecure_if,
  input  logic                     arst_n_i,
  input  xsecure_pkg::fetch_item_t push_i,
  input  logic                     pop_i,
  output logic [`XSEC_ILEN-1:0]    head_o,
  output logic                     empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`XSEC_ILEN-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i.valid && !full;
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge xsecure_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop leave the occupancy unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge xsecure_if) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_i.instr;
    end
  end

  // Overflow means the source ignored the idle-cycle rule between strobes
  a_no_push_full: assert property (@(posedge xsecure_if) disable iff (!arst_n_i)
    push_i.valid |-> !full);

  // The issue stage must only pop a non-empty queue
  a_no_pop_empty: assert property (@(posedge xsecure_if) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

endmodule

/* source/issue_stage.sv */
`include "xsecure_defines.svh"

module issue_stage (
  input  logic                     xsecure_if,
  input  logic                     arst_n_i,
  input  xsecure_pkg::dummy_req_t  dummy_req_i,
  input  logic [`XSEC_ILEN-1:0]    head_i,
  input  logic                     empty_i,
  output logic                     pop_o,
  output logic                     dummy_taken_o,
  output logic                     real_issued_o,
  output xsecure_pkg::issue_item_t issue_o,
  output logic [`XSEC_CNT_W-1:0]   minstret_o
);

  logic                   take_dummy;
  logic                   take_real;
  logic                   valid_q;
  logic                   dummy_q;
  logic [`XSEC_ILEN-1:0]  instr_q;
  logic [`XSEC_CNT_W-1:0] minstret_q;

  //////////////////////////////////////////////////
  // Selection
  //////////////////////////////////////////////////

  // A pending dummy wins over the queue head and at most one item issues per cycle
  assign take_dummy = dummy_req_i.valid;
  assign take_real  = !dummy_req_i.valid && !empty_i;

  // Strobes back to the queue, the LFSR bank and the scheduler
  assign pop_o         = take_real;
  assign real_issued_o = take_real;
  assign dummy_taken_o = take_dummy;

  //////////////////////////////////////////////////
  // Output register and retired counter
  //////////////////////////////////////////////////

  always_ff @(posedge xsecure_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q    <= 1'b0;
      dummy_q    <= 1'b0;
      minstret_q <= '0;
    end else begin
      valid_q <= take_dummy || take_real;
      dummy_q <= take_dummy;
      // Dummies never retire so only real items advance the count
      if (take_real) begin
        minstret_q <= minstret_q + 1'b1;
      end
    end
  end

  always_ff @(posedge xsecure_if) begin
    if (take_dummy) begin
      instr_q <= dummy_req_i.instr;
    end else if (take_real) begin
      instr_q <= head_i;
    end
  end

  assign issue_o.valid = valid_q;
  assign issue_o.dummy = dummy_q;
  assign issue_o.instr = instr_q;
  assign minstret_o    = minstret_q;

endmodule

/* source/xsecure_defines.svh */
`ifndef XSECURE_DEFINES_SVH
`define XSECURE_DEFINES_SVH

// Width of one instruction word
`define XSEC_ILEN 32

// All three LFSRs share one width
`define XSEC_LFSR_W 32

// Default seeds, loaded at reset and after a lockup, must all be nonzero
`define XSEC_LFSR0_SEED 32'h9A3C_52E1
`define XSEC_LFSR1_SEED 32'h4D17_B08F
`define XSEC_LFSR2_SEED 32'hC6E2_7A35

// Galois tap mask for x^32 + x^22 + x^2 + x + 1, shifting right
`define XSEC_LFSR_TAPS 32'h8020_0003

// Default number of entries in the fetch queue
`define XSEC_FIFO_DEPTH 4

// Major opcodes used by the dummy instructions
`define XSEC_OPC_OP     7'b0110011
`define XSEC_OPC_BRANCH 7'b1100011

// Dummy frequency code and its decode patterns, for use in casez
`define XSEC_FREQ_W  4
`define XSEC_FREQ_4  4'b0000
`define XSEC_FREQ_8  4'b0001
`define XSEC_FREQ_16 4'b001?
`define XSEC_FREQ_32 4'b01??
`define XSEC_FREQ_64 4'b1???

// Width of the retired instruction counter
`define XSEC_CNT_W 32

`endif

/* source/xsecure_dummy_top.sv */
`include "xsecure_defines.svh"

module xsecure_dummy_top (
  input  logic                     xsecure_if,
  input  logic                     arst_n_i,
  input  xsecure_pkg::fetch_item_t fetch_i,
  input  xsecure_pkg::seed_wr_t    seed_wr_i,
  input  logic                     rnddummy_i,
  input  logic [`XSEC_FREQ_W-1:0]  rnddummyfreq_i,
  output xsecure_pkg::issue_item_t issue_o,
  output logic                     alert_minor_o,
  output logic [`XSEC_CNT_W-1:0]   minstret_o
);
  import xsecure_pkg::*;

  lfsr_taps_t            taps;
  dummy_req_t            dummy_req;
  logic                  dummy_taken;
  logic                  real_issued;
  logic                  fifo_pop;
  logic                  fifo_empty;
  logic [`XSEC_ILEN-1:0] fifo_head;

  // Producer side, random source stepped by each taken dummy
  xsecure_lfsr_bank u_lfsr_bank (
    .xsecure_if    (xsecure_if),
    .arst_n_i      (arst_n_i),
    .seed_wr_i     (seed_wr_i),
    .step_i        (dummy_taken),
    .taps_o        (taps),
    .alert_minor_o (alert_minor_o)
  );

  // Producer side, decides when a dummy is due and what it looks like
  dummy_instr_sched u_sched (
    .xsecure_if     (xsecure_if),
    .arst_n_i       (arst_n_i),
    .rnddummy_i     (rnddummy_i),
    .rnddummyfreq_i (rnddummyfreq_i),
    .taps_i         (taps),
    .real_issued_i  (real_issued),
    .dummy_taken_i  (dummy_taken),
    .dummy_req_o    (dummy_req)
  );

  // Buffers fetched words while dummies occupy the issue slot
  fetch_fifo #(
    .DEPTH (`XSEC_FIFO_DEPTH)
  ) u_fifo (
    .xsecure_if (xsecure_if),
    .arst_n_i   (arst_n_i),
    .push_i     (fetch_i),
    .pop_i      (fifo_pop),
    .head_o     (fifo_head),
    .empty_o    (fifo_empty)
  );

  issue_stage u_issue (
    .xsecure_if    (xsecure_if),
    .arst_n_i      (arst_n_i),
    .dummy_req_i   (dummy_req),
    .head_i        (fifo_head),
    .empty_i       (fifo_empty),
    .pop_o         (fifo_pop),
    .dummy_taken_o (dummy_taken),
    .real_issued_o (real_issued),
    .issue_o       (issue_o),
    .minstret_o    (minstret_o)
  );

endmodule

/* source/xsecure_lfsr_bank.sv */
`include "xsecure_defines.svh"

module xsecure_lfsr_bank (
  input  logic                    xsecure_if,
  input  logic                    arst_n_i,
  input  xsecure_pkg::seed_wr_t   seed_wr_i,
  input  logic                    step_i,
  output xsecure_pkg::lfsr_taps_t taps_o,
  output logic                    alert_minor_o
);

  // Index k of this vector is the default seed of LFSR k
  localparam logic [2:0][`XSEC_LFSR_W-1:0] DEFAULT_SEED = {
    `XSEC_LFSR2_SEED,
    `XSEC_LFSR1_SEED,
    `XSEC_LFSR0_SEED
  };

  logic [2:0][`XSEC_LFSR_W-1:0] lfsr_q;
  logic [2:0][`XSEC_LFSR_W-1:0] lfsr_d;
  logic [2:0]                   lockup;
  logic                         alert_q;

  // One right shift of a Galois LFSR
  // A nonzero state never steps into zero, so zero only comes from a seed write
  function automatic logic [`XSEC_LFSR_W-1:0] galois_step(
    input logic [`XSEC_LFSR_W-1:0] state
  );
    logic [`XSEC_LFSR_W-1:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ `XSEC_LFSR_TAPS;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  // Priority per LFSR: seed write, then lockup reseed, then stepping
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      lockup[k] = (lfsr_q[k] == '0);
      if (seed_wr_i.we[k]) begin
        lfsr_d[k] = seed_wr_i.data;
      end else if (lockup[k]) begin
        lfsr_d[k] = DEFAULT_SEED[k];
      end else if (step_i) begin
        lfsr_d[k] = galois_step(lfsr_q[k]);
      end else begin
        lfsr_d[k] = lfsr_q[k];
      end
    end
  end

  // The alert is registered, so it follows the lockup cycle by one
  always_ff @(posedge xsecure_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q  <= DEFAULT_SEED;
      alert_q <= 1'b0;
    end else begin
      lfsr_q  <= lfsr_d;
      alert_q <= |lockup;
    end
  end

  // The scheduler only sees the low bits it needs
  assign taps_o.lfsr1   = lfsr_q[1][4:0];
  assign taps_o.lfsr2   = lfsr_q[2][4:0];
  assign taps_o.lfsr0   = lfsr_q[0][7:0];
  assign alert_minor_o  = alert_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Without a competing seed write, a lockup raises the alert and restores the default seed
  for (genvar k = 0; k < 3; k++) begin : g_lockup_chk
    a_lockup_reseed: assert property (@(posedge xsecure_if) disable iff (!arst_n_i)
      lockup[k] && !seed_wr_i.we[k] |=> alert_minor_o && lfsr_q[k] == DEFAULT_SEED[k]);
  end

endmodule

/* source/xsecure_pkg.sv */
`include "xsecure_defines.svh"

package xsecure_pkg;

  //////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////

  // Register-register layout, used for ADD, AND and MUL dummies
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // Branch layout, the offset is split over the upper and lower fields
  typedef struct packed {
    logic [6:0] offset_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] offset_lo;
    logic [6:0] opcode;
  } btype_t;

  // One 32-bit word decoded either way
  typedef union packed {
    rtype_t r;
    btype_t b;
  } instr_word_u;

  //////////////////////////////////////////////////
  // Interface bundles
  //////////////////////////////////////////////////

  // Fetched word with its single-cycle strobe
  typedef struct packed {
    logic                  valid;
    logic [`XSEC_ILEN-1:0] instr;
  } fetch_item_t;

  // Issued word, the dummy flag separates inserted items from real ones
  typedef struct packed {
    logic                  valid;
    logic                  dummy;
    logic [`XSEC_ILEN-1:0] instr;
  } issue_item_t;

  // Seed write, one enable bit per LFSR and shared data
  typedef struct packed {
    logic [2:0]              we;
    logic [`XSEC_LFSR_W-1:0] data;
  } seed_wr_t;

  // Low LFSR bits used to build and schedule dummies
  typedef struct packed {
    logic [4:0] lfsr1;
    logic [4:0] lfsr2;
    logic [7:0] lfsr0;
  } lfsr_taps_t;

  // Pending dummy, held until the issue stage takes it
  typedef struct packed {
    logic        valid;
    instr_word_u instr;
  } dummy_req_t;

endpackage

/* verification/tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset starts low so the DUT sees a falling edge at time zero
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* verification/tb_xsecure_dummy.sv */
`include "xsecure_defines.svh"

module tb_xsecure_dummy;
  timeunit 1ns;
  timeprecision 1ps;
  import xsecure_pkg::*;

  localparam int N_PLAIN        = 24;
  localparam int N_PER_CODE     = 40;
  localparam int N_WORDS        = N_PLAIN + 16 * N_PER_CODE;
  localparam int TIMEOUT_CYCLES = N_WORDS * 8 + 200;

  logic                   clk;
  logic                   arst_n;
  fetch_item_t            fetch_i;
  seed_wr_t               seed_wr_i;
  logic                   rnddummy_i;
  logic [`XSEC_FREQ_W-1:0] rnddummyfreq_i;
  issue_item_t            issue_o;
  logic                   alert_minor_o;
  logic [`XSEC_CNT_W-1:0] minstret_o;

  // The driver pushes sent words into the model queue and the compare process pops them
  logic [`XSEC_ILEN-1:0]   exp_q[$];
  logic                    dummy_en;
  logic [`XSEC_FREQ_W-1:0] cur_code;
  int mismatch_cnt = 0;
  int other_cnt    = 0;
  int reals_seen   = 0;
  int dummies_seen = 0;
  int sent_cnt     = 0;
  int cycle_cnt    = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (arst_n)
  );

  xsecure_dummy_top dut_i (
    .xsecure_if     (clk),
    .arst_n_i       (arst_n),
    .fetch_i        (fetch_i),
    .seed_wr_i      (seed_wr_i),
    .rnddummy_i     (rnddummy_i),
    .rnddummyfreq_i (rnddummyfreq_i),
    .issue_o        (issue_o),
    .alert_minor_o  (alert_minor_o),
    .minstret_o     (minstret_o)
  );

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  // Upper bound on real items between dummies follows the highest set bit of the code
  function automatic int freq_limit(input logic [`XSEC_FREQ_W-1:0] code);
    if (code[3]) return 64;
    if (code[2]) return 32;
    if (code[1]) return 16;
    if (code[0]) return 8;
    return 4;
  endfunction

  // Legal dummies are ADD, AND, MUL with rd x0, or BLTU with a zero offset
  function automatic bit dummy_is_legal(input instr_word_u w);
    if (w.r.rd != 5'd0) return 1'b0;
    if (w.r.opcode == 7'b0110011) begin
      if (w.r.funct7 == 7'd0 && (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b111)) return 1'b1;
      return w.r.funct7 == 7'b0000001 && w.r.funct3 == 3'b000;
    end
    if (w.b.opcode == 7'b1100011) begin
      return w.b.funct3 == 3'b110 && w.b.offset_hi == 7'd0 && w.b.offset_lo == 5'd0;
    end
    return 1'b0;
  endfunction

  // Fields other than valid only count when an item is expected
  task automatic check_issue(input issue_item_t exp, input issue_item_t act, input string what);
    if (act.valid !== exp.valid ||
        (exp.valid && (act.dummy !== exp.dummy || act.instr !== exp.instr))) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s expected v=%0b d=%0b %08h, got v=%0b d=%0b %08h", $time,
               what, exp.valid, exp.dummy, exp.instr, act.valid, act.dummy, act.instr);
    end
  endtask

  task automatic check_count(input logic [`XSEC_CNT_W-1:0] exp,
                             input logic [`XSEC_CNT_W-1:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: minstret expected %0d, got %0d", $time, exp, act);
    end
  endtask

  task automatic check_alert(input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: alert_minor expected %0b, got %0b", $time, exp, act);
    end
  endtask

  // Outputs are sampled on the falling edge half a cycle after the DUT updates them
  always @(negedge clk) begin : compare
    logic [1:0]  zero_hist;
    logic        zero_now;
    int          since_dummy;
    issue_item_t exp_item;
    if (!arst_n) begin
      zero_hist   = '0;
      since_dummy = 0;
    end else begin
      // A zero seed write shows up as the alert two cycles later
      zero_now = (|seed_wr_i.we) && (seed_wr_i.data == '0);
      check_alert(zero_hist[1], alert_minor_o);
      zero_hist = {zero_hist[0], zero_now};
      // The scheduler restarts its count whenever insertion is off
      if (!dummy_en) since_dummy = 0;
      if (issue_o.valid && issue_o.dummy) begin
        dummies_seen++;
        if (!dummy_en) begin
          other_cnt++;
          $display("error at %0t: dummy issued while insertion was disabled", $time);
        end
        if (!dummy_is_legal(issue_o.instr)) begin
          mismatch_cnt++;
          $display("mismatch at %0t: illegal dummy word %08h", $time, issue_o.instr);
        end
        if (since_dummy < 1 || since_dummy > freq_limit(cur_code)) begin
          mismatch_cnt++;
          $display("mismatch at %0t: %0d real items before dummy, limit %0d", $time,
                   since_dummy, freq_limit(cur_code));
        end
        since_dummy = 0;
      end else if (issue_o.valid) begin
        if (exp_q.size() == 0) begin
          other_cnt++;
          $display("error at %0t: real item %08h issued with nothing sent", $time,
                   issue_o.instr);
        end else begin
          exp_item = '{valid: 1'b1, dummy: 1'b0, instr: exp_q.pop_front()};
          check_issue(exp_item, issue_o, "real item");
        end
        reals_seen++;
        since_dummy++;
        check_count(reals_seen, minstret_o);
      end
    end
  end

  // Run limit scaled to the number of words the test sends
  always @(posedge clk) begin
    if (arst_n) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        other_cnt++;
        $display("error: timeout after %0d cycles, %0d sent words never issued",
                 cycle_cnt, exp_q.size());
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("RESULT: FAIL");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // One strobe followed by at least one idle cycle before the next
  task automatic send_word(input logic [`XSEC_ILEN-1:0] word);
    int gap;
    gap = $urandom_range(0, 2);
    @(posedge clk);
    fetch_i <= '{valid: 1'b1, instr: word};
    exp_q.push_back(word);
    sent_cnt++;
    @(posedge clk);
    fetch_i <= '0;
    repeat (gap) @(posedge clk);
  endtask

  task automatic write_seed(input logic [2:0] we, input logic [`XSEC_LFSR_W-1:0] data);
    @(posedge clk);
    seed_wr_i <= '{we: we, data: data};
    @(posedge clk);
    seed_wr_i <= '0;
    repeat (4) @(posedge clk);
  endtask

  task automatic set_dummy(input logic en, input logic [`XSEC_FREQ_W-1:0] code);
    @(posedge clk);
    rnddummy_i     <= en;
    rnddummyfreq_i <= code;
    dummy_en = en;
    cur_code = code;
  endtask

  // Queue empty plus a few cycles lets a pending dummy come out too
  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
  endtask

  initial begin
    issue_item_t idle_item;
    void'($urandom(32'h7a16_d447));
    fetch_i        = '0;
    seed_wr_i      = '0;
    rnddummy_i     = 1'b0;
    rnddummyfreq_i = '0;
    dummy_en       = 1'b0;
    cur_code       = '0;
    idle_item      = '0;
    @(posedge arst_n);
    @(negedge clk);
    check_issue(idle_item, issue_o, "after reset");
    check_count('0, minstret_o);

    // Plain forwarding with no dummies expected
    repeat (N_PLAIN) send_word($urandom());
    wait_drain();

    // Zero writes lock up an LFSR while nonzero writes stay silent
    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) write_seed(3'($urandom_range(1, 7)), '0);
      else write_seed(3'($urandom_range(1, 7)), $urandom() | 32'd1);
    end

    // Dummy insertion across every frequency code
    for (int code = 0; code < 16; code++) begin
      set_dummy(1'b1, 4'(code));
      repeat (N_PER_CODE) send_word($urandom());
      wait_drain();
      set_dummy(1'b0, 4'(code));
    end
    repeat (4) @(posedge clk);

    @(negedge clk);
    check_count(sent_cnt, minstret_o);
    if (exp_q.size() != 0) begin
      other_cnt++;
      $display("error: %0d sent words were never issued", exp_q.size());
    end
    if (dummies_seen == 0) begin
      other_cnt++;
      $display("error: no dummy instruction was issued with insertion enabled");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* xsecure_dummy.f */
+incdir+source
source/xsecure_pkg.sv
source/xsecure_lfsr_bank.sv
source/dummy_instr_sched.sv
source/fetch_fifo.sv
source/issue_stage.sv
source/xsecure_dummy_top.sv
verification/tb_clk_gen.sv
verification/tb_xsecure_dummy.sv
